/* build.f */
+incdir+include
hw/idu_pkg.sv
hw/idu_operand_if.sv
hw/idu_opcode_decoder.sv
hw/idu_issue_reg.sv
hw/idu_operand_unit.sv
hw/idu_top.sv
verification/idu_properties.sv
verification/tb_idu.sv

/* hw/idu_issue_reg.sv */
// ======================================
// Single-entry issue buffer for decoded
// fields, valid/ready and flush clearing
// ======================================

module idu_issue_reg (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  in_valid_i,
   output logic                  in_ready_o,
   output logic                  out_valid_o,
   input  logic                  out_ready_i,
   input  logic                  flush_i,
   input  idu_pkg::decode_ctrl_t ctrl_i,
   output idu_pkg::decode_ctrl_t ctrl_o,
   output logic                  accept_o
);

   import idu_pkg::*;

   logic         out_valid_q;
   decode_ctrl_t data_q;
   logic         emu_insn_q;
   logic         mu_load_q;
   logic         mu_store_q;
   logic         mu_barr_q;
   logic         mu_sign_ext_q;
   logic         wb_regf_q;
   logic         load;

   // Free slot, or the slot drains this cycle
   assign in_ready_o  = ~out_valid_q | out_ready_i;
   assign accept_o    = in_valid_i & in_ready_o;
   assign out_valid_o = out_valid_q;
   assign load        = accept_o | flush_i;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_valid_q <= 1'b0;
      end else if (accept_o) begin
         out_valid_q <= 1'b1;
      end else if (out_ready_i) begin
         out_valid_q <= 1'b0;
      end
   end

   // Side-effect fields are squashed by a flush
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         emu_insn_q    <= 1'b0;
         mu_load_q     <= 1'b0;
         mu_store_q    <= 1'b0;
         mu_barr_q     <= 1'b0;
         mu_sign_ext_q <= 1'b0;
         wb_regf_q     <= 1'b0;
      end else if (load) begin
         emu_insn_q    <= ctrl_i.emu_insn & ~flush_i;
         mu_load_q     <= ctrl_i.mu_load & ~flush_i;
         mu_store_q    <= ctrl_i.mu_store & ~flush_i;
         mu_barr_q     <= ctrl_i.mu_barr & ~flush_i;
         mu_sign_ext_q <= ctrl_i.mu_sign_ext & ~flush_i;
         wb_regf_q     <= ctrl_i.wb_regf & ~flush_i;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         data_q <= ctrl_i;
      end
   end

   always_comb begin
      ctrl_o             = data_q;
      ctrl_o.emu_insn    = emu_insn_q;
      ctrl_o.mu_load     = mu_load_q;
      ctrl_o.mu_store    = mu_store_q;
      ctrl_o.mu_barr     = mu_barr_q;
      ctrl_o.mu_sign_ext = mu_sign_ext_q;
      ctrl_o.wb_regf     = wb_regf_q;
   end

endmodule

/* hw/idu_opcode_decoder.sv */
// ======================================
// Opcode decoder: control fields, register
// read requests and extended immediate
// ======================================

`include "idu_defines.svh"

module idu_opcode_decoder (
   input  logic [`IDU_IW-1:0]   insn_i,
   output idu_pkg::decode_ctrl_t ctrl_o,
   idu_operand_if.decoder       opnd_if
);

   import idu_pkg::*;

   // Instruction fields
   wire [5:0]  f_opcode = insn_i[`IDU_F_OPC_HI:`IDU_F_OPC_LO];
   wire [5:0]  f_rd     = insn_i[`IDU_F_RD_HI:`IDU_F_RD_LO];
   wire [5:0]  f_rs1    = insn_i[`IDU_F_RS1_HI:`IDU_F_RS1_LO];
   wire [5:0]  f_rs2    = insn_i[`IDU_F_RS2_HI:`IDU_F_RS2_LO];
   wire [7:0]  f_attr   = insn_i[`IDU_F_ATTR_HI:`IDU_F_ATTR_LO];
   wire [13:0] f_imm14  = insn_i[`IDU_F_IMM14_HI:`IDU_F_IMM14_LO];
   wire [17:0] f_imm18  = insn_i[`IDU_F_IMM18_HI:`IDU_F_IMM18_LO];

   wire op_ldb   = (f_opcode == `IDU_OP_LDB);
   wire op_ldbu  = (f_opcode == `IDU_OP_LDBU);
   wire op_ldh   = (f_opcode == `IDU_OP_LDH);
   wire op_ldhu  = (f_opcode == `IDU_OP_LDHU);
   wire op_ldwu  = (f_opcode == `IDU_OP_LDWU);
   wire op_stb   = (f_opcode == `IDU_OP_STB);
   wire op_sth   = (f_opcode == `IDU_OP_STH);
   wire op_stw   = (f_opcode == `IDU_OP_STW);
   wire op_and   = (f_opcode == `IDU_OP_AND);
   wire op_and_i = (f_opcode == `IDU_OP_AND_I);
   wire op_or    = (f_opcode == `IDU_OP_OR);
   wire op_or_i  = (f_opcode == `IDU_OP_OR_I);
   wire op_xor   = (f_opcode == `IDU_OP_XOR);
   wire op_xor_i = (f_opcode == `IDU_OP_XOR_I);
   wire op_lsl   = (f_opcode == `IDU_OP_LSL);
   wire op_lsl_i = (f_opcode == `IDU_OP_LSL_I);
   wire op_lsr   = (f_opcode == `IDU_OP_LSR);
   wire op_lsr_i = (f_opcode == `IDU_OP_LSR_I);
   wire op_asr   = (f_opcode == `IDU_OP_ASR);
   wire op_asr_i = (f_opcode == `IDU_OP_ASR_I);
   wire op_cmp   = (f_opcode == `IDU_OP_CMP);
   wire op_add   = (f_opcode == `IDU_OP_ADD);
   wire op_add_i = (f_opcode == `IDU_OP_ADD_I);
   wire op_sub   = (f_opcode == `IDU_OP_SUB);
   wire op_mul   = (f_opcode == `IDU_OP_MUL);
   wire op_div   = (f_opcode == `IDU_OP_DIV);
   wire op_divu  = (f_opcode == `IDU_OP_DIVU);
   wire op_mod   = (f_opcode == `IDU_OP_MOD);
   wire op_modu  = (f_opcode == `IDU_OP_MODU);
   wire op_mhi   = (f_opcode == `IDU_OP_MHI);
   wire op_wmsr  = (f_opcode == `IDU_OP_WMSR);
   wire op_rmsr  = (f_opcode == `IDU_OP_RMSR);
   wire op_mbarr = (f_opcode == `IDU_OP_MBARR);

   wire op_load  = op_ldb | op_ldbu | op_ldh | op_ldhu | op_ldwu;
   wire op_store = op_stb | op_sth | op_stw;

   // Forms taking the 14-bit immediate as second operand
   wire insn_imm14 = op_and_i | op_or_i | op_xor_i | op_lsl_i | op_lsr_i | op_asr_i |
                     op_add_i | op_load | op_store | op_wmsr | op_rmsr;
   wire imm14_signed = op_xor_i | op_add_i | op_load | op_store;
   wire rd_as_rs2    = op_store | op_wmsr;
   wire reg_reg_form = ~(insn_imm14 | op_mhi | op_mbarr);

   wire [`IDU_DW-1:0] simm14 = {{(`IDU_DW-14){f_imm14[13]}}, f_imm14};
   wire [`IDU_DW-1:0] uimm14 = {{(`IDU_DW-14){1'b0}}, f_imm14};
   wire [`IDU_DW-1:0] uimm18 = {{(`IDU_DW-18){1'b0}}, f_imm18};

   always_comb begin
      ctrl_o = '0;
      ctrl_o.lu_opc.op_and = op_and | op_and_i;
      ctrl_o.lu_opc.op_or  = op_or | op_or_i;
      ctrl_o.lu_opc.op_xor = op_xor | op_xor_i;
      ctrl_o.lu_opc.op_lsl = op_lsl | op_lsl_i;
      ctrl_o.lu_opc.op_lsr = op_lsr | op_lsr_i;
      ctrl_o.lu_opc.op_asr = op_asr | op_asr_i;
      ctrl_o.au_opc.cmp    = op_cmp;
      ctrl_o.au_opc.add    = op_add | op_add_i;
      ctrl_o.au_opc.sub    = op_sub;
      ctrl_o.au_opc.mul    = op_mul;
      ctrl_o.au_opc.div    = op_div;
      ctrl_o.au_opc.divu   = op_divu;
      ctrl_o.au_opc.mod    = op_mod;
      ctrl_o.au_opc.modu   = op_modu;
      ctrl_o.au_opc.mhi    = op_mhi;
      ctrl_o.eu_opc.wmsr   = op_wmsr;
      ctrl_o.eu_opc.rmsr   = op_rmsr;
      ctrl_o.cmp_eq        = op_cmp & (f_attr == `IDU_ATTR_EQ);
      ctrl_o.cmp_signed    = op_cmp & (f_attr == `IDU_ATTR_GT);
      ctrl_o.load_size     = (op_ldb | op_ldbu) ? MEM_BYTE :
                             (op_ldh | op_ldhu) ? MEM_HALF :
                             op_ldwu ? MEM_WORD : MEM_NONE;
      ctrl_o.store_size    = op_stb ? MEM_BYTE : op_sth ? MEM_HALF :
                             op_stw ? MEM_WORD : MEM_NONE;
      ctrl_o.wb_reg_addr   = f_rd[`IDU_REG_AW-1:0];
      ctrl_o.mu_load       = op_load;
      ctrl_o.mu_store      = op_store;
      ctrl_o.mu_barr       = op_mbarr;
      ctrl_o.mu_sign_ext   = op_ldb | op_ldh;
      // Anything not matched above goes to the emulation trap
      ctrl_o.emu_insn      = ~((|ctrl_o.lu_opc) | (|ctrl_o.au_opc) | (|ctrl_o.eu_opc) |
                               op_load | op_store | op_mbarr);
      ctrl_o.wb_regf       = ~(op_mbarr | op_cmp | op_store | op_wmsr | ctrl_o.emu_insn);
   end

   // Register file requests
   assign opnd_if.rs1_req   = ~op_mbarr;
   assign opnd_if.rs2_req   = reg_reg_form | rd_as_rs2;
   assign opnd_if.rs2_is_rd = rd_as_rs2;
   assign opnd_if.rs1_addr  = f_rs1[`IDU_REG_AW-1:0];
   assign opnd_if.rs2_addr  = rd_as_rs2 ? f_rd[`IDU_REG_AW-1:0] : f_rs2[`IDU_REG_AW-1:0];

   assign opnd_if.imm = insn_imm14 ? (imm14_signed ? simm14 : uimm14) : uimm18;

endmodule

/* hw/idu_operand_if.sv */
// ======================================
// Operand requests and immediate from
// the decoder to the operand unit
// ======================================

interface idu_operand_if;

   import idu_pkg::*;

   logic      rs1_req;
   logic      rs2_req;
   // Second read port fetches rd instead of rs2
   logic      rs2_is_rd;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   word_t     imm;

   modport decoder (
      output rs1_req,
      output rs2_req,
      output rs2_is_rd,
      output rs1_addr,
      output rs2_addr,
      output imm
   );

   modport operand (
      input rs1_req,
      input rs2_req,
      input rs2_is_rd,
      input rs1_addr,
      input rs2_addr,
      input imm
   );

endinterface

/* hw/idu_operand_unit.sv */
// ======================================
// Register file reads, immediate and the
// three execute operands
// ======================================

module idu_operand_unit (
   input  logic               clk,
   input  logic               rst_n_i,
   input  logic               accept_i,
   idu_operand_if.operand     opnd_if,
   output logic               rs1_re_o,
   output logic               rs2_re_o,
   output idu_pkg::reg_addr_t rs1_addr_o,
   output idu_pkg::reg_addr_t rs2_addr_o,
   input  idu_pkg::word_t     rs1_dout_i,
   input  idu_pkg::word_t     rs2_dout_i,
   output idu_pkg::word_t     operand_1_o,
   output idu_pkg::word_t     operand_2_o,
   output idu_pkg::word_t     operand_3_o
);

   import idu_pkg::*;

   logic  rs1_frm_regf_q;
   logic  rs2_frm_regf_q;
   logic  rd_as_rs2_q;
   word_t imm_q;

   // Reads only go out with an accepted instruction
   assign rs1_re_o   = opnd_if.rs1_req & accept_i;
   assign rs2_re_o   = opnd_if.rs2_req & accept_i;
   assign rs1_addr_o = opnd_if.rs1_addr;
   assign rs2_addr_o = opnd_if.rs2_addr;

   // Operand sources, one cycle ahead of the register data
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rs1_frm_regf_q <= 1'b0;
         rs2_frm_regf_q <= 1'b0;
         rd_as_rs2_q    <= 1'b0;
      end else if (accept_i) begin
         rs1_frm_regf_q <= opnd_if.rs1_req;
         rs2_frm_regf_q <= opnd_if.rs2_req & ~opnd_if.rs2_is_rd;
         rd_as_rs2_q    <= opnd_if.rs2_is_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (accept_i) begin
         imm_q <= opnd_if.imm;
      end
   end

   // Register file holds its data until the next read
   assign operand_1_o = rs1_frm_regf_q ? rs1_dout_i : imm_q;
   assign operand_2_o = rs2_frm_regf_q ? rs2_dout_i : imm_q;
   // Store data or value for wmsr
   assign operand_3_o = rd_as_rs2_q ? rs2_dout_i : '0;

endmodule

/* hw/idu_pkg.sv */
// ======================================
// Decode stage types: data word, register
// number, opcode buses, decoded fields
// ======================================

`include "idu_defines.svh"

package idu_pkg;

   typedef logic [`IDU_DW-1:0]     word_t;
   typedef logic [`IDU_REG_AW-1:0] reg_addr_t;

   // Logic unit one-hot bus
   typedef struct packed {
      logic op_and;
      logic op_or;
      logic op_xor;
      logic op_lsl;
      logic op_lsr;
      logic op_asr;
   } lu_opc_t;

   // Arithmetic unit one-hot bus
   typedef struct packed {
      logic cmp;
      logic add;
      logic sub;
      logic mul;
      logic div;
      logic divu;
      logic mod;
      logic modu;
      logic mhi;
   } au_opc_t;

   // Special-register unit
   typedef struct packed {
      logic wmsr;
      logic rmsr;
   } eu_opc_t;

   // Memory access size
   typedef enum logic [2:0] {
      MEM_NONE = 3'd0,
      MEM_BYTE = 3'd1,
      MEM_HALF = 3'd2,
      MEM_WORD = 3'd3
   } mem_size_t;

   typedef struct packed {
      // Data fields, kept through a flush
      lu_opc_t   lu_opc;
      au_opc_t   au_opc;
      eu_opc_t   eu_opc;
      logic      cmp_eq;
      logic      cmp_signed;
      mem_size_t load_size;
      mem_size_t store_size;
      reg_addr_t wb_reg_addr;
      // Control fields with side effects
      logic      emu_insn;
      logic      mu_load;
      logic      mu_store;
      logic      mu_barr;
      logic      mu_sign_ext;
      logic      wb_regf;
   } decode_ctrl_t;

endpackage

/* hw/idu_top.sv */
// ======================================
// Instruction decode stage top level
// ======================================

`include "idu_defines.svh"

module idu_top (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  idu_in_valid_i,
   output logic                  idu_in_ready_o,
   input  logic [`IDU_IW-1:0]    idu_insn_i,
   input  logic                  flush_i,
   output logic                  regf_rs1_re_o,
   output logic                  regf_rs2_re_o,
   output idu_pkg::reg_addr_t    regf_rs1_addr_o,
   output idu_pkg::reg_addr_t    regf_rs2_addr_o,
   input  idu_pkg::word_t        regf_rs1_dout_i,
   input  idu_pkg::word_t        regf_rs2_dout_i,
   input  logic                  ieu_in_ready_i,
   output logic                  ieu_in_valid_o,
   output idu_pkg::word_t        ieu_operand_1_o,
   output idu_pkg::word_t        ieu_operand_2_o,
   output idu_pkg::word_t        ieu_operand_3_o,
   output idu_pkg::lu_opc_t      ieu_lu_opc_o,
   output idu_pkg::au_opc_t      ieu_au_opc_o,
   output idu_pkg::eu_opc_t      ieu_eu_opc_o,
   output logic                  ieu_au_cmp_eq_o,
   output logic                  ieu_au_cmp_signed_o,
   output logic                  ieu_emu_insn_o,
   output logic                  ieu_mu_load_o,
   output logic                  ieu_mu_store_o,
   output logic                  ieu_mu_sign_ext_o,
   output logic                  ieu_mu_barr_o,
   output logic                  ieu_wb_regf_o,
   output idu_pkg::mem_size_t    ieu_mu_load_size_o,
   output idu_pkg::mem_size_t    ieu_mu_store_size_o,
   output idu_pkg::reg_addr_t    ieu_wb_reg_addr_o
);

   import idu_pkg::*;

   decode_ctrl_t dec_ctrl;
   decode_ctrl_t ieu_ctrl;
   logic         accept;

   idu_operand_if opnd_if ();

   idu_opcode_decoder i_decoder (
      .insn_i  (idu_insn_i),
      .ctrl_o  (dec_ctrl),
      .opnd_if (opnd_if.decoder)
   );

   idu_issue_reg i_issue_reg (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .in_valid_i  (idu_in_valid_i),
      .in_ready_o  (idu_in_ready_o),
      .out_valid_o (ieu_in_valid_o),
      .out_ready_i (ieu_in_ready_i),
      .flush_i     (flush_i),
      .ctrl_i      (dec_ctrl),
      .ctrl_o      (ieu_ctrl),
      .accept_o    (accept)
   );

   idu_operand_unit i_operand_unit (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .accept_i    (accept),
      .opnd_if     (opnd_if.operand),
      .rs1_re_o    (regf_rs1_re_o),
      .rs2_re_o    (regf_rs2_re_o),
      .rs1_addr_o  (regf_rs1_addr_o),
      .rs2_addr_o  (regf_rs2_addr_o),
      .rs1_dout_i  (regf_rs1_dout_i),
      .rs2_dout_i  (regf_rs2_dout_i),
      .operand_1_o (ieu_operand_1_o),
      .operand_2_o (ieu_operand_2_o),
      .operand_3_o (ieu_operand_3_o)
   );

   // Registered fields out to the execute stage
   assign ieu_lu_opc_o        = ieu_ctrl.lu_opc;
   assign ieu_au_opc_o        = ieu_ctrl.au_opc;
   assign ieu_eu_opc_o        = ieu_ctrl.eu_opc;
   assign ieu_au_cmp_eq_o     = ieu_ctrl.cmp_eq;
   assign ieu_au_cmp_signed_o = ieu_ctrl.cmp_signed;
   assign ieu_emu_insn_o      = ieu_ctrl.emu_insn;
   assign ieu_mu_load_o       = ieu_ctrl.mu_load;
   assign ieu_mu_store_o      = ieu_ctrl.mu_store;
   assign ieu_mu_sign_ext_o   = ieu_ctrl.mu_sign_ext;
   assign ieu_mu_barr_o       = ieu_ctrl.mu_barr;
   assign ieu_wb_regf_o       = ieu_ctrl.wb_regf;
   assign ieu_mu_load_size_o  = ieu_ctrl.load_size;
   assign ieu_mu_store_size_o = ieu_ctrl.store_size;
   assign ieu_wb_reg_addr_o   = ieu_ctrl.wb_reg_addr;

endmodule

/* include/idu_defines.svh */
// ======================================
// Decode stage widths, instruction fields,
// opcode values and compare attributes
// ======================================

`ifndef IDU_DEFINES_SVH
`define IDU_DEFINES_SVH

// Widths
`define IDU_DW              32
`define IDU_REG_AW          5
`define IDU_IW              32

// Instruction fields
`define IDU_F_OPC_LO        0
`define IDU_F_OPC_HI        5
`define IDU_F_RD_LO         6
`define IDU_F_RD_HI         11
`define IDU_F_RS1_LO        12
`define IDU_F_RS1_HI        17
`define IDU_F_RS2_LO        18
`define IDU_F_RS2_HI        23
`define IDU_F_ATTR_LO       24
`define IDU_F_ATTR_HI       31
`define IDU_F_IMM14_LO      18
`define IDU_F_IMM14_HI      31
`define IDU_F_IMM18_LO      12
`define IDU_F_IMM18_HI      29

// Logic unit
`define IDU_OP_AND          6'h02
`define IDU_OP_AND_I        6'h03
`define IDU_OP_OR           6'h04
`define IDU_OP_OR_I         6'h05
`define IDU_OP_XOR          6'h06
`define IDU_OP_XOR_I        6'h07
`define IDU_OP_LSL          6'h08
`define IDU_OP_LSL_I        6'h09
`define IDU_OP_LSR          6'h0a
`define IDU_OP_LSR_I        6'h0b
`define IDU_OP_ASR          6'h0c
`define IDU_OP_ASR_I        6'h0d

// Arithmetic unit
`define IDU_OP_CMP          6'h0e
`define IDU_OP_ADD          6'h0f
`define IDU_OP_ADD_I        6'h10
`define IDU_OP_SUB          6'h11
`define IDU_OP_MUL          6'h12
`define IDU_OP_DIV          6'h13
`define IDU_OP_DIVU         6'h14
`define IDU_OP_MOD          6'h15
`define IDU_OP_MODU         6'h16
`define IDU_OP_MHI          6'h17

// Memory access
`define IDU_OP_LDB          6'h18
`define IDU_OP_LDBU         6'h19
`define IDU_OP_LDH          6'h1a
`define IDU_OP_LDHU         6'h1b
`define IDU_OP_LDWU         6'h1c
`define IDU_OP_STB          6'h1d
`define IDU_OP_STH          6'h1e
`define IDU_OP_STW          6'h1f

// Special registers and barrier
`define IDU_OP_WMSR         6'h20
`define IDU_OP_RMSR         6'h21
`define IDU_OP_MBARR        6'h22

// cmp attribute field
`define IDU_ATTR_EQ         8'h01
`define IDU_ATTR_GT         8'h02

`endif

/* verification/idu_properties.sv */
// ======================================
// Bound assertions on the decode stage
// handshake, read enables and flush
// ======================================

module idu_properties (
   input logic clk,
   input logic rst_n_i,
   input logic flush_i,
   input logic in_ready_i,
   input logic out_valid_i,
   input logic rs1_re_i,
   input logic rs2_re_i,
   input logic emu_insn_i,
   input logic mu_load_i,
   input logic mu_store_i,
   input logic mu_barr_i,
   input logic mu_sign_ext_i,
   input logic wb_regf_i
);

   int error_count = 0;

   wire side_effects = emu_insn_i | mu_load_i | mu_store_i | mu_barr_i |
                       mu_sign_ext_i | wb_regf_i;

   // Output stage comes out of reset empty
   valid_low_after_reset: assert property (
      @(posedge clk) !rst_n_i |=> !out_valid_i
   ) else begin
      error_count++;
      $error("ieu_in_valid_o is set after reset");
   end

   // A stalled stage must not start a register read
   no_read_while_stalled: assert property (
      @(posedge clk) disable iff (!rst_n_i) !in_ready_i |-> !(rs1_re_i || rs2_re_i)
   ) else begin
      error_count++;
      $error("register read enable asserted while idu_in_ready_o is low");
   end

   flush_clears_controls: assert property (
      @(posedge clk) disable iff (!rst_n_i) flush_i |=> !side_effects
   ) else begin
      error_count++;
      $error("control outputs not cleared in the cycle after flush_i");
   end

endmodule

bind idu_top idu_properties i_idu_properties (
   .clk           (clk),
   .rst_n_i       (rst_n_i),
   .flush_i       (flush_i),
   .in_ready_i    (idu_in_ready_o),
   .out_valid_i   (ieu_in_valid_o),
   .rs1_re_i      (regf_rs1_re_o),
   .rs2_re_i      (regf_rs2_re_o),
   .emu_insn_i    (ieu_emu_insn_o),
   .mu_load_i     (ieu_mu_load_o),
   .mu_store_i    (ieu_mu_store_o),
   .mu_barr_i     (ieu_mu_barr_o),
   .mu_sign_ext_i (ieu_mu_sign_ext_o),
   .wb_regf_i     (ieu_wb_regf_o)
);

/* verification/tb_idu.sv */
// ======================================
// Decode stage testbench: clock, reset,
// register file model and directed tests
// ======================================

`include "idu_defines.svh"

module tb_idu;

   import idu_pkg::*;

   localparam int TIMEOUT = 20;

   logic      clk;
   logic      rst_n;
   logic      idu_in_valid;
   logic      idu_in_ready;
   logic [31:0] idu_insn;
   logic      flush;
   logic      rs1_re;
   logic      rs2_re;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   word_t     rs1_dout = '0;
   word_t     rs2_dout = '0;
   logic      ieu_in_ready;
   logic      ieu_in_valid;
   word_t     ieu_operand_1;
   word_t     ieu_operand_2;
   word_t     ieu_operand_3;
   lu_opc_t   ieu_lu_opc;
   au_opc_t   ieu_au_opc;
   eu_opc_t   ieu_eu_opc;
   logic      ieu_au_cmp_eq;
   logic      ieu_au_cmp_signed;
   logic      ieu_emu_insn;
   logic      ieu_mu_load;
   logic      ieu_mu_store;
   logic      ieu_mu_sign_ext;
   logic      ieu_mu_barr;
   logic      ieu_wb_regf;
   mem_size_t ieu_mu_load_size;
   mem_size_t ieu_mu_store_size;
   reg_addr_t ieu_wb_reg_addr;

   word_t     regs [32];
   logic      accept_seen = 1'b0;
   string     cur_test;

   idu_top i_idu_top (
      .clk                 (clk),
      .rst_n_i             (rst_n),
      .idu_in_valid_i      (idu_in_valid),
      .idu_in_ready_o      (idu_in_ready),
      .idu_insn_i          (idu_insn),
      .flush_i             (flush),
      .regf_rs1_re_o       (rs1_re),
      .regf_rs2_re_o       (rs2_re),
      .regf_rs1_addr_o     (rs1_addr),
      .regf_rs2_addr_o     (rs2_addr),
      .regf_rs1_dout_i     (rs1_dout),
      .regf_rs2_dout_i     (rs2_dout),
      .ieu_in_ready_i      (ieu_in_ready),
      .ieu_in_valid_o      (ieu_in_valid),
      .ieu_operand_1_o     (ieu_operand_1),
      .ieu_operand_2_o     (ieu_operand_2),
      .ieu_operand_3_o     (ieu_operand_3),
      .ieu_lu_opc_o        (ieu_lu_opc),
      .ieu_au_opc_o        (ieu_au_opc),
      .ieu_eu_opc_o        (ieu_eu_opc),
      .ieu_au_cmp_eq_o     (ieu_au_cmp_eq),
      .ieu_au_cmp_signed_o (ieu_au_cmp_signed),
      .ieu_emu_insn_o      (ieu_emu_insn),
      .ieu_mu_load_o       (ieu_mu_load),
      .ieu_mu_store_o      (ieu_mu_store),
      .ieu_mu_sign_ext_o   (ieu_mu_sign_ext),
      .ieu_mu_barr_o       (ieu_mu_barr),
      .ieu_wb_regf_o       (ieu_wb_regf),
      .ieu_mu_load_size_o  (ieu_mu_load_size),
      .ieu_mu_store_size_o (ieu_mu_store_size),
      .ieu_wb_reg_addr_o   (ieu_wb_reg_addr)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   // Register file answers one cycle after a read and holds its data
   always @(posedge clk) begin
      if (rs1_re) begin
         rs1_dout <= regs[rs1_addr];
      end
      if (rs2_re) begin
         rs2_dout <= regs[rs2_addr];
      end
   end

   always @(posedge clk) begin
      accept_seen <= idu_in_valid & idu_in_ready;
   end

   always @(negedge clk) begin
      assert (i_idu_top.i_idu_properties.error_count == 0) else begin
         $display("A bound assertion on the DUT failed");
         stop_run();
      end
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic fill_regfile();
      logic [31:0] s;
      s = 32'd73655;
      for (int i = 0; i < 32; i++) begin
         for (int b = 0; b < 32; b++) begin
            s = lfsr_step(s);
            regs[i][b] = s[0];
         end
      end
   endtask

   function automatic logic [31:0] rr_insn(input logic [5:0] op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [7:0] attr);
      return {attr, 1'b0, rs2, 1'b0, rs1, 1'b0, rd, op};
   endfunction

   function automatic logic [31:0] imm14_insn(input logic [5:0] op, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [13:0] imm);
      return {imm, 1'b0, rs1, 1'b0, rd, op};
   endfunction

   function automatic logic [31:0] imm18_insn(input logic [5:0] op, input logic [4:0] rd,
                                              input logic [17:0] imm);
      return {2'b00, imm, 1'b0, rd, op};
   endfunction

   task automatic stop_run();
      $display("FAIL: see errors above");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_eq(input string field, input logic [31:0] exp,
                           input logic [31:0] act);
      assert (act === exp) else begin
         $display("[ERROR] %s %s: expected %0h, actual %0h", cur_test, field, exp, act);
         stop_run();
      end
   endtask

   // Called on a falling edge with the instruction already on the bus
   task automatic wait_accept();
      int cycles;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) begin
            $display("Timeout in %s: the instruction was never accepted", cur_test);
            stop_run();
         end
      end while (!accept_seen);
      idu_in_valid = 1'b0;
   endtask

   task automatic wait_out_valid();
      int cycles;
      cycles = 0;
      while (!ieu_in_valid) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) begin
            $display("Timeout in %s: ieu_in_valid_o never rose", cur_test);
            stop_run();
         end
      end
   endtask

   task automatic issue_insn(input logic [31:0] insn);
      idu_insn = insn;
      idu_in_valid = 1'b1;
      wait_accept();
      wait_out_valid();
   endtask

   task automatic alu_case(input logic [5:0] op, input lu_opc_t lu, input au_opc_t au,
                           input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
      issue_insn(rr_insn(op, rd, rs1, rs2, 8'h00));
      check_eq("lu_opc", lu, ieu_lu_opc);
      check_eq("au_opc", au, ieu_au_opc);
      check_eq("eu_opc", 32'h0, ieu_eu_opc);
      check_eq("emu_insn", 1'b0, ieu_emu_insn);
      check_eq("mu_barr", 1'b0, ieu_mu_barr);
      check_eq("operand_1", regs[rs1], ieu_operand_1);
      check_eq("operand_2", regs[rs2], ieu_operand_2);
      check_eq("wb_regf", 1'b1, ieu_wb_regf);
      check_eq("wb_reg_addr", rd, ieu_wb_reg_addr);
   endtask

   task automatic test_reg_alu();
      lu_opc_t lu;
      au_opc_t au;
      cur_test = "reg_alu";
      lu = '0;
      au = '0;
      au.add = 1'b1;
      alu_case(`IDU_OP_ADD, lu, au, 5'd3, 5'd7, 5'd12);
      au = '0;
      au.sub = 1'b1;
      alu_case(`IDU_OP_SUB, lu, au, 5'd4, 5'd1, 5'd30);
      au = '0;
      lu.op_xor = 1'b1;
      alu_case(`IDU_OP_XOR, lu, au, 5'd17, 5'd22, 5'd9);
      lu = '0;
      lu.op_asr = 1'b1;
      alu_case(`IDU_OP_ASR, lu, au, 5'd31, 5'd16, 5'd5);
   endtask

   task automatic test_immediates();
      logic [13:0] imm;
      logic [17:0] imm18;
      cur_test = "immediates";
      // Negative 14-bit immediate, sign extended
      imm = 14'h3f85;
      issue_insn(imm14_insn(`IDU_OP_ADD_I, 5'd4, 5'd9, imm));
      check_eq("au_opc.add", 1'b1, ieu_au_opc.add);
      check_eq("operand_1", regs[9], ieu_operand_1);
      check_eq("operand_2", {{18{imm[13]}}, imm}, ieu_operand_2);
      imm = 14'h2a31;
      issue_insn(imm14_insn(`IDU_OP_OR_I, 5'd6, 5'd14, imm));
      check_eq("lu_opc.op_or", 1'b1, ieu_lu_opc.op_or);
      check_eq("operand_2", {18'h0, imm}, ieu_operand_2);
      imm18 = 18'h2c0d5;
      issue_insn(imm18_insn(`IDU_OP_MHI, 5'd11, imm18));
      check_eq("au_opc.mhi", 1'b1, ieu_au_opc.mhi);
      check_eq("operand_2", {14'h0, imm18}, ieu_operand_2);
      check_eq("wb_regf", 1'b1, ieu_wb_regf);
      check_eq("wb_reg_addr", 5'd11, ieu_wb_reg_addr);
   endtask

   task automatic mem_case(input logic [5:0] op, input logic is_store, input mem_size_t ld_size,
                           input mem_size_t st_size, input logic sext);
      logic [13:0] imm;
      imm = 14'h3ff0;
      issue_insn(imm14_insn(op, 5'd21, 5'd2, imm));
      check_eq("mu_load", !is_store, ieu_mu_load);
      check_eq("mu_store", is_store, ieu_mu_store);
      check_eq("load_size", ld_size, ieu_mu_load_size);
      check_eq("store_size", st_size, ieu_mu_store_size);
      check_eq("sign_ext", sext, ieu_mu_sign_ext);
      check_eq("wb_regf", !is_store, ieu_wb_regf);
      check_eq("operand_1", regs[2], ieu_operand_1);
      check_eq("operand_2", {{18{imm[13]}}, imm}, ieu_operand_2);
      check_eq("operand_3", is_store ? regs[21] : 32'h0, ieu_operand_3);
   endtask

   task automatic test_mem();
      cur_test = "loads_stores";
      mem_case(`IDU_OP_LDB, 1'b0, MEM_BYTE, MEM_NONE, 1'b1);
      mem_case(`IDU_OP_LDBU, 1'b0, MEM_BYTE, MEM_NONE, 1'b0);
      mem_case(`IDU_OP_LDH, 1'b0, MEM_HALF, MEM_NONE, 1'b1);
      mem_case(`IDU_OP_LDHU, 1'b0, MEM_HALF, MEM_NONE, 1'b0);
      mem_case(`IDU_OP_LDWU, 1'b0, MEM_WORD, MEM_NONE, 1'b0);
      mem_case(`IDU_OP_STB, 1'b1, MEM_NONE, MEM_BYTE, 1'b0);
      mem_case(`IDU_OP_STH, 1'b1, MEM_NONE, MEM_HALF, 1'b0);
      mem_case(`IDU_OP_STW, 1'b1, MEM_NONE, MEM_WORD, 1'b0);
   endtask

   task automatic test_cmp_eu_emu();
      eu_opc_t eu;
      logic [17:0] imm18;
      cur_test = "cmp_eu_emu";
      issue_insn(rr_insn(`IDU_OP_CMP, 5'd0, 5'd8, 5'd19, `IDU_ATTR_EQ));
      check_eq("au_opc.cmp", 1'b1, ieu_au_opc.cmp);
      check_eq("cmp_eq", 1'b1, ieu_au_cmp_eq);
      check_eq("cmp_signed", 1'b0, ieu_au_cmp_signed);
      check_eq("wb_regf", 1'b0, ieu_wb_regf);
      check_eq("operand_2", regs[19], ieu_operand_2);
      issue_insn(rr_insn(`IDU_OP_CMP, 5'd0, 5'd8, 5'd19, `IDU_ATTR_GT));
      check_eq("cmp_eq", 1'b0, ieu_au_cmp_eq);
      check_eq("cmp_signed", 1'b1, ieu_au_cmp_signed);
      eu = '0;
      eu.wmsr = 1'b1;
      issue_insn(imm14_insn(`IDU_OP_WMSR, 5'd13, 5'd6, 14'h0042));
      check_eq("eu_opc", eu, ieu_eu_opc);
      check_eq("operand_3", regs[13], ieu_operand_3);
      check_eq("wb_regf", 1'b0, ieu_wb_regf);
      // Barrier reads no register, so operand 1 is the immediate
      imm18 = 18'h01234;
      issue_insn(imm18_insn(`IDU_OP_MBARR, 5'd0, imm18));
      check_eq("mu_barr", 1'b1, ieu_mu_barr);
      check_eq("emu_insn", 1'b0, ieu_emu_insn);
      check_eq("wb_regf", 1'b0, ieu_wb_regf);
      check_eq("operand_1", {14'h0, imm18}, ieu_operand_1);
      // 6'h3f is not assigned to any instruction
      issue_insn(rr_insn(6'h3f, 5'd1, 5'd2, 5'd3, 8'h00));
      check_eq("emu_insn", 1'b1, ieu_emu_insn);
      check_eq("lu_opc", 32'h0, ieu_lu_opc);
      check_eq("au_opc", 32'h0, ieu_au_opc);
      check_eq("eu_opc", 32'h0, ieu_eu_opc);
      check_eq("mu_barr", 1'b0, ieu_mu_barr);
      check_eq("wb_regf", 1'b0, ieu_wb_regf);
   endtask

   task automatic test_backpressure();
      word_t op1;
      word_t op2;
      cur_test = "backpressure";
      issue_insn(rr_insn(`IDU_OP_SUB, 5'd8, 5'd1, 5'd2, 8'h00));
      // Execute stage stalls with the sub in the stage
      ieu_in_ready = 1'b0;
      op1 = ieu_operand_1;
      op2 = ieu_operand_2;
      check_eq("operand_1", regs[1], op1);
      check_eq("operand_2", regs[2], op2);
      // Second instruction waits on the bus
      idu_insn = rr_insn(`IDU_OP_ADD, 5'd9, 5'd3, 5'd4, 8'h00);
      idu_in_valid = 1'b1;
      repeat (4) begin
         @(negedge clk);
         check_eq("idu_in_ready", 1'b0, idu_in_ready);
         check_eq("ieu_in_valid", 1'b1, ieu_in_valid);
         check_eq("accept while stalled", 1'b0, accept_seen);
         check_eq("held operand_1", op1, ieu_operand_1);
         check_eq("held operand_2", op2, ieu_operand_2);
         check_eq("held au_opc.sub", 1'b1, ieu_au_opc.sub);
         check_eq("held wb_reg_addr", 5'd8, ieu_wb_reg_addr);
      end
      ieu_in_ready = 1'b1;
      wait_accept();
      wait_out_valid();
      check_eq("au_opc.add", 1'b1, ieu_au_opc.add);
      check_eq("operand_1", regs[3], ieu_operand_1);
      check_eq("operand_2", regs[4], ieu_operand_2);
      check_eq("wb_reg_addr", 5'd9, ieu_wb_reg_addr);
   endtask

   task automatic test_flush();
      cur_test = "flush";
      issue_insn(imm14_insn(`IDU_OP_LDB, 5'd10, 5'd11, 14'h0100));
      check_eq("mu_load", 1'b1, ieu_mu_load);
      check_eq("wb_regf", 1'b1, ieu_wb_regf);
      // The load stays on the instruction bus through the flush
      ieu_in_ready = 1'b0;
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
      check_eq("mu_load", 1'b0, ieu_mu_load);
      check_eq("wb_regf", 1'b0, ieu_wb_regf);
      check_eq("sign_ext", 1'b0, ieu_mu_sign_ext);
      check_eq("load_size", MEM_BYTE, ieu_mu_load_size);
      check_eq("wb_reg_addr", 5'd10, ieu_wb_reg_addr);
      ieu_in_ready = 1'b1;
      @(negedge clk);
      check_eq("ieu_in_valid", 1'b0, ieu_in_valid);
   endtask

   initial begin
      rst_n = 1'b0;
      idu_in_valid = 1'b0;
      idu_insn = '0;
      flush = 1'b0;
      ieu_in_ready = 1'b1;
      cur_test = "reset";
      fill_regfile();
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      test_reg_alu();
      test_immediates();
      test_mem();
      test_cmp_eu_emu();
      test_backpressure();
      test_flush();
      if (i_idu_top.i_idu_properties.error_count == 0) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         stop_run();
      end
   end

endmodule
